//--- video_pkg.sv
////////////////////////////////////////////////////////////
// Pixel format is RGB 8:8:8 with red in the top byte
// Blanking length applies to both output copies of a line
////////////////////////////////////////////////////////////

package video_pkg;

  // Channel geometry
  localparam int CHAN_W = 8;
  localparam int N_CHAN = 3;
  localparam int PIX_W  = CHAN_W * N_CHAN;

  // One colour channel, used by the scanline dimmer
  typedef logic [CHAN_W-1:0] chan_t;

  // Packed pixel, R in [23:16], G in [15:8], B in [7:0]
  typedef logic [PIX_W-1:0] pixel_t;

  // rdCLK cycles of blank ahead of each output copy
  localparam int H_BLANK = 16;

  // Output line timer
  typedef enum logic [2:0] {
    IDLE,
    BLANK1,
    ACTIVE1,
    BLANK2,
    ACTIVE2
  } scan_state_t;

endpackage

//--- lbuf_pkg.sv
////////////////////////////////////////////////////////////
// Two banks of 256 pixels, bank select is the top address bit
// Input lines longer than LINE_MAX are clipped
////////////////////////////////////////////////////////////

package lbuf_pkg;

  // Pixel position inside one bank
  localparam int HPOS_W = 8;

  // Longest line that is stored
  localparam int LINE_MAX = 2 ** HPOS_W;

  // Bank bit plus position
  localparam int LBUF_AW = HPOS_W + 1;

  // Position 0..255
  typedef logic [HPOS_W-1:0] hpos_t;

  // Length 0..256, one bit wider than a position
  typedef logic [HPOS_W:0] llen_t;

  // Full buffer address {bank, hpos}
  typedef logic [LBUF_AW-1:0] lbuf_addr_t;

endpackage

//--- cap_if.sv
////////////////////////////////////////////////////////////
// All signals belong to the wrCLK domain
// bank and line_len change on the same edge, once per line
////////////////////////////////////////////////////////////

interface cap_if;
  import video_pkg::*;
  import lbuf_pkg::*;

  // Write group for the line buffer
  logic       wr_en;
  lbuf_addr_t wr_addr;
  pixel_t     wr_data;

  // Line status
  // Bank currently being filled
  logic       bank;
  // Length of the last finished line
  llen_t      line_len;

  // Capture side drives everything
  modport src (output wr_en, wr_addr, wr_data, bank, line_len);

  // Write group only, as seen from its source
  modport wr_src (output wr_en, wr_addr, wr_data);

  // Readers of the line status
  modport stat (input bank, line_len);

endinterface

//--- scan_if.sv
////////////////////////////////////////////////////////////
// rdCLK domain, driven straight from the timer state
////////////////////////////////////////////////////////////

interface scan_if;
  import lbuf_pkg::*;

  // High while a pixel is fetched
  logic  active;
  // Pixel index within the line
  hpos_t hpos;
  // Repeat copy, covers BLANK2 and ACTIVE2
  logic  second_copy;
  // First cycle of each blank
  logic  hsync_start;

  // Timer side
  modport src (output active, hpos, second_copy, hsync_start);

  // Combiner side
  modport dst (input active, hpos, second_copy, hsync_start);

endinterface

//--- n64a_ram2port.sv
////////////////////////////////////////////////////////////
// Read data appears two rdCLK cycles after rden and rdaddr
// No read-during-write bypass, same-address access is undefined
////////////////////////////////////////////////////////////

module n64a_ram2port #(
  parameter int ram_depth  = 10,
  parameter int data_width = 32
) (
  input  logic                  wrCLK,
  input  logic                  wren,
  input  logic [ram_depth-1:0]  wraddr,
  input  logic [data_width-1:0] wrdata,
  input  logic                  rdCLK,
  input  logic                  rden,
  input  logic [ram_depth-1:0]  rdaddr,
  output logic [data_width-1:0] rddata
);

  // Storage array
  logic [data_width-1:0] data_buf [0:(2**ram_depth)-1];

  //////////////////////////////////////////////////////////////
  // Write side

  // Input register stage
  logic                  wren_r = 1'b0;
  logic [ram_depth-1:0]  wraddr_r;
  logic [data_width-1:0] wrdata_r;

  always_ff @(posedge wrCLK) begin
    wren_r   <= wren;
    wraddr_r <= wraddr;
    wrdata_r <= wrdata;
    // Array update one cycle after the port
    if (wren_r) begin
      data_buf[wraddr_r] <= wrdata_r;
    end
  end

  //////////////////////////////////////////////////////////////
  // Read side

  logic                 rden_r = 1'b0;
  logic [ram_depth-1:0] rdaddr_r;

  always_ff @(posedge rdCLK) begin
    rden_r   <= rden;
    rdaddr_r <= rdaddr;
    // Output holds its last word while rden_r is low
    if (rden_r) begin
      rddata <= data_buf[rdaddr_r];
    end
  end

endmodule

//--- line_capture.sv
////////////////////////////////////////////////////////////
// Pixels with in_de high are stored, at most LINE_MAX per line
// Bank flips on the first edge with in_de low after a line
// A line without pixels leaves bank and line_len unchanged
////////////////////////////////////////////////////////////

module line_capture (
  input  logic              wrCLK,
  input  logic              rst_n,
  input  logic              in_de,
  input  video_pkg::pixel_t in_pixel,
  cap_if.src                cap
);
  import lbuf_pkg::*;

  // Pixels accepted so far in this line
  llen_t pos;
  // Line reached LINE_MAX, further pixels are dropped
  logic  full;

  assign full = (pos == llen_t'(LINE_MAX));

  // Write port
  // RAM registers these once and writes on the next edge
  assign cap.wr_en   = in_de && !full;
  assign cap.wr_addr = {cap.bank, pos[HPOS_W-1:0]};
  assign cap.wr_data = in_pixel;

  //////////////////////////////////////////////////////////////
  // Position counter and line end

  always_ff @(posedge wrCLK or negedge rst_n) begin
    if (!rst_n) begin
      pos          <= '0;
      cap.bank     <= 1'b0;
      cap.line_len <= '0;
    end else if (in_de) begin
      // Saturate at the bank size
      if (!full) begin
        pos <= pos + 1'b1;
      end
    end else begin
      // Non-zero count with in_de low marks the falling edge
      if (pos != '0) begin
        cap.line_len <= pos;
        cap.bank     <= ~cap.bank;
      end
      pos <= '0;
    end
  end

  //////////////////////////////////////////////////////////////
  // Checks

  // Bank still matches the address bit when the RAM commits the write
  a_wr_bank: assert property (
    @(posedge wrCLK) disable iff (!rst_n)
      cap.wr_en |=> (cap.bank == $past(cap.wr_addr[LBUF_AW-1]))
  );

  // Reported length fits the bank
  a_len_max: assert property (
    @(posedge wrCLK) disable iff (!rst_n)
      cap.line_len <= llen_t'(LINE_MAX)
  );

endmodule

//--- scan_timer.sv
////////////////////////////////////////////////////////////
// rdCLK must be twice wrCLK and phase aligned with it
// A bank change seen outside IDLE is ignored, its line is lost
////////////////////////////////////////////////////////////

module scan_timer (
  input  logic rdCLK,
  input  logic rst_n,
  cap_if.stat  cap,
  scan_if.src  scan
);
  import video_pkg::*;
  import lbuf_pkg::*;

  scan_state_t state;
  // Shared counter for blank and active periods
  llen_t       cnt;
  // Line length held for both copies
  llen_t       len_q;
  // Bank sampled from the write domain, plus one delay
  logic        bank_q;
  logic        bank_qq;
  logic        new_line;
  logic        blank_end;
  logic        act_end;

  // New finished line, one cycle after the sample
  assign new_line  = bank_q ^ bank_qq;
  assign blank_end = (cnt == llen_t'(H_BLANK - 1));
  assign act_end   = (cnt == len_q - 1'b1);

  always_ff @(posedge rdCLK or negedge rst_n) begin
    if (!rst_n) begin
      bank_q  <= 1'b0;
      bank_qq <= 1'b0;
    end else begin
      bank_q  <= cap.bank;
      bank_qq <= bank_q;
    end
  end

  //////////////////////////////////////////////////////////////
  // Line FSM

  always_ff @(posedge rdCLK or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      cnt   <= '0;
      len_q <= '0;
    end else begin
      case (state)
        IDLE: begin
          cnt <= '0;
          // Length is stable for the whole next input line
          if (new_line) begin
            len_q <= cap.line_len;
            state <= BLANK1;
          end
        end
        BLANK1, BLANK2: begin
          if (blank_end) begin
            cnt   <= '0;
            state <= (state == BLANK1) ? ACTIVE1 : ACTIVE2;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        ACTIVE1, ACTIVE2: begin
          if (act_end) begin
            cnt   <= '0;
            state <= (state == ACTIVE1) ? BLANK2 : IDLE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Outputs decoded from the state register
  assign scan.active      = (state == ACTIVE1) || (state == ACTIVE2);
  assign scan.second_copy = (state == BLANK2) || (state == ACTIVE2);
  assign scan.hsync_start = ((state == BLANK1) || (state == BLANK2)) && (cnt == '0);
  assign scan.hpos        = cnt[HPOS_W-1:0];

  // Fetch index stays inside the captured line
  a_hpos_len: assert property (
    @(posedge rdCLK) disable iff (!rst_n)
      scan.active |-> ({1'b0, scan.hpos} < len_q)
  );

endmodule

//--- line_output.sv
////////////////////////////////////////////////////////////
// Outputs trail the timer by three rdCLK cycles
// Reads the bank opposite to the one being written
// Scanline dimming scales the repeat copy to 3/4 per channel
////////////////////////////////////////////////////////////

module line_output (
  input  logic                 rdCLK,
  input  logic                 rst_n,
  input  logic                 scanline_en,
  cap_if.stat                  cap,
  scan_if.dst                  scan,
  output logic                 rden,
  output lbuf_pkg::lbuf_addr_t rdaddr,
  input  video_pkg::pixel_t    rddata,
  output logic                 out_de,
  output logic                 out_hsync,
  output video_pkg::pixel_t    out_pixel
);
  import video_pkg::*;

  // Two-stage delays matching the RAM read latency
  logic [1:0] de_d;
  logic [1:0] hs_d;
  logic [1:0] sc_d;
  // Pixel after optional dimming
  pixel_t     dimmed;
  logic       dim_on;

  // Three quarters of c without underflow
  function automatic chan_t dim_chan(input chan_t c);
    return c - (c >> 2);
  endfunction

  //////////////////////////////////////////////////////////////
  // Fetch

  // Address and enable in the same cycle as active
  assign rden   = scan.active;
  assign rdaddr = {~cap.bank, scan.hpos};

  always_ff @(posedge rdCLK or negedge rst_n) begin
    if (!rst_n) begin
      de_d <= '0;
      hs_d <= '0;
      sc_d <= '0;
    end else begin
      de_d <= {de_d[0], scan.active};
      hs_d <= {hs_d[0], scan.hsync_start};
      sc_d <= {sc_d[0], scan.second_copy};
    end
  end

  //////////////////////////////////////////////////////////////
  // Dimming

  // Only the repeat copy is dimmed
  assign dim_on = sc_d[1] && scanline_en;

  always_comb begin
    for (int i = 0; i < N_CHAN; i++) begin
      if (dim_on) begin
        dimmed[i*CHAN_W +: CHAN_W] = dim_chan(rddata[i*CHAN_W +: CHAN_W]);
      end else begin
        dimmed[i*CHAN_W +: CHAN_W] = rddata[i*CHAN_W +: CHAN_W];
      end
    end
  end

  // Output register
  // Pixel forced to zero outside the active window
  always_ff @(posedge rdCLK or negedge rst_n) begin
    if (!rst_n) begin
      out_de    <= 1'b0;
      out_hsync <= 1'b0;
      out_pixel <= '0;
    end else begin
      out_de    <= de_d[1];
      out_hsync <= hs_d[1];
      out_pixel <= de_d[1] ? dimmed : '0;
    end
  end

  // Sync pulse falls in blanking and leads the first pixel by H_BLANK
  a_hs_de: assert property (
    @(posedge rdCLK) disable iff (!rst_n)
      out_hsync |-> !out_de ##H_BLANK out_de
  );

endmodule

//--- linedbl_top.sv
////////////////////////////////////////////////////////////
// rdCLK runs at exactly twice wrCLK, edges aligned
// Input blank must last at least H_BLANK/2 wrCLK cycles
// Lines arriving during playback are dropped
////////////////////////////////////////////////////////////

module linedbl_top (
  input  logic              wrCLK,
  input  logic              rdCLK,
  input  logic              rst_n,
  input  logic              in_de,
  input  video_pkg::pixel_t in_pixel,
  input  logic              scanline_en,
  output logic              out_de,
  output logic              out_hsync,
  output video_pkg::pixel_t out_pixel
);
  import video_pkg::*;
  import lbuf_pkg::*;

  // Read port between combiner and buffer
  logic       rden;
  lbuf_addr_t rdaddr;
  pixel_t     rddata;

  // Write group and line status, wrCLK domain
  cap_if  cap_bus ();
  // Output timing, rdCLK domain
  scan_if scan_bus ();

  //////////////////////////////////////////////////////////////
  // Write domain

  line_capture u_capture (
    .wrCLK    (wrCLK),
    .rst_n    (rst_n),
    .in_de    (in_de),
    .in_pixel (in_pixel),
    .cap      (cap_bus)
  );

  // Two-bank line buffer
  n64a_ram2port #(
    .ram_depth  (LBUF_AW),
    .data_width ($bits(pixel_t))
  ) u_lbuf (
    .wrCLK  (wrCLK),
    .wren   (cap_bus.wr_en),
    .wraddr (cap_bus.wr_addr),
    .wrdata (cap_bus.wr_data),
    .rdCLK  (rdCLK),
    .rden   (rden),
    .rdaddr (rdaddr),
    .rddata (rddata)
  );

  //////////////////////////////////////////////////////////////
  // Read domain

  scan_timer u_timer (
    .rdCLK (rdCLK),
    .rst_n (rst_n),
    .cap   (cap_bus),
    .scan  (scan_bus)
  );

  line_output u_output (
    .rdCLK       (rdCLK),
    .rst_n       (rst_n),
    .scanline_en (scanline_en),
    .cap         (cap_bus),
    .scan        (scan_bus),
    .rden        (rden),
    .rdaddr      (rdaddr),
    .rddata      (rddata),
    .out_de      (out_de),
    .out_hsync   (out_hsync),
    .out_pixel   (out_pixel)
  );

endmodule

//--- linedbl_checker.sv
////////////////////////////////////////////////////////////
// Assumes lines are spaced so that none is dropped by the DUT
// scanline_en may change only while no line is played back
////////////////////////////////////////////////////////////

module linedbl_checker (
  input  logic              wrCLK,
  input  logic              rdCLK,
  input  logic              rst_n,
  input  logic              in_de,
  input  video_pkg::pixel_t in_pixel,
  input  logic              scanline_en,
  input  logic              out_de,
  input  logic              out_hsync,
  input  video_pkg::pixel_t out_pixel,
  output int                err_cnt,
  output int                chk_cnt,
  output int                lines_done,
  output int                hsync_cnt,
  output int                de_cnt
);
  import video_pkg::*;
  import lbuf_pkg::*;

  // Pixels of all pending lines, oldest line first
  pixel_t line_pix [$];
  int     line_len [$];
  // Input line in progress, counts past LINE_MAX
  int     cur_len;
  // Position inside the copy now on the output
  int     pix_idx;
  logic   second;
  logic   de_q;
  // scanline_en as the output register saw it
  logic   dim_q;
  pixel_t exp_pix;
  int     drop_len;

  // Expected output pixel
  // Dimmed channel is 3/4 of c, rounded up
  function automatic pixel_t expect_pixel(input pixel_t p, input logic rep, input logic dim);
    pixel_t r;
    int     c;
    r = p;
    if (rep && dim) begin
      for (int k = 0; k < N_CHAN; k++) begin
        c = p[k*CHAN_W +: CHAN_W];
        c = (3 * c + 3) / 4;
        r[k*CHAN_W +: CHAN_W] = c[CHAN_W-1:0];
      end
    end
    return r;
  endfunction

  //////////////////////////////////////////////////////////////
  // Input side, one line per falling in_de

  always @(posedge wrCLK) begin
    if (!rst_n) begin
      cur_len = 0;
    end else if (in_de) begin
      // Pixels past the bank size are not stored
      if (cur_len < LINE_MAX) begin
        line_pix.push_back(in_pixel);
      end
      cur_len++;
    end else if (cur_len != 0) begin
      line_len.push_back((cur_len < LINE_MAX) ? cur_len : LINE_MAX);
      cur_len = 0;
    end
  end

  //////////////////////////////////////////////////////////////
  // Output side

  // Closes one copy, the line leaves the queue after its repeat
  task finish_copy();
    if (line_len.size() != 0) begin
      if (pix_idx != line_len[0]) begin
        $display("Output copy held %0d pixels where the line has %0d", pix_idx, line_len[0]);
        err_cnt++;
      end
      if (second) begin
        drop_len = line_len.pop_front();
        for (int k = 0; k < drop_len; k++) begin
          void'(line_pix.pop_front());
        end
        lines_done++;
      end
      second = ~second;
    end
    pix_idx = 0;
  endtask

  always @(posedge rdCLK) begin
    if (!rst_n) begin
      err_cnt    = 0;
      chk_cnt    = 0;
      lines_done = 0;
      hsync_cnt  = 0;
      de_cnt     = 0;
      pix_idx    = 0;
      second     = 1'b0;
      de_q       = 1'b0;
      dim_q      = 1'b0;
    end else begin
      chk_cnt++;
      if (out_hsync) begin
        hsync_cnt++;
      end
      if (out_de) begin
        de_cnt++;
        if (line_len.size() == 0) begin
          $display("Output active at time %0t with no captured line waiting", $time);
          err_cnt++;
        end else if (pix_idx >= line_len[0]) begin
          $display("Output copy runs past the %0d pixels of its line", line_len[0]);
          err_cnt++;
        end else begin
          exp_pix = expect_pixel(line_pix[pix_idx], second, dim_q);
          if (out_pixel !== exp_pix) begin
            $display("Error: out_pixel expected %h got %h (copy %0d, pixel %0d)",
                     exp_pix, out_pixel, int'(second) + 1, pix_idx);
            err_cnt++;
          end
        end
        pix_idx++;
      end else begin
        // Blank pixels are black
        if (out_pixel !== '0) begin
          $display("Error: out_pixel expected %h got %h outside out_de", pixel_t'(0), out_pixel);
          err_cnt++;
        end
        if (de_q) begin
          finish_copy();
        end
      end
      de_q  = out_de;
      dim_q = scanline_en;
    end
  end

endmodule

//--- tb_linedbl.sv
////////////////////////////////////////////////////////////
// rdCLK period 20, wrCLK period 40 with rising edges aligned
// Each line is followed by a blank that outlasts its playback
////////////////////////////////////////////////////////////

module tb_linedbl;
  import video_pkg::*;

  logic   wrCLK;
  logic   rdCLK;
  logic   rst_n;
  logic   in_de;
  pixel_t in_pixel;
  logic   scanline_en;
  logic   out_de;
  logic   out_hsync;
  pixel_t out_pixel;

  // Counters kept by the checker
  int err_cnt;
  int chk_cnt;
  int lines_done;
  int hsync_cnt;
  int de_cnt;

  integer seed;
  int     fail_cnt;
  int     test_cnt;
  // Counter values at the start of a test
  int     err_base;
  int     lines_base;
  int     hs_base;
  int     de_base;
  logic   timed_out;

  // Both clocks from one loop, wrCLK flips on every rdCLK rise
  initial begin
    rdCLK = 1'b0;
    wrCLK = 1'b0;
    forever begin
      #10;
      rdCLK = 1'b1;
      wrCLK = ~wrCLK;
      #10;
      rdCLK = 1'b0;
    end
  end

  linedbl_top dut0 (
    .wrCLK       (wrCLK),
    .rdCLK       (rdCLK),
    .rst_n       (rst_n),
    .in_de       (in_de),
    .in_pixel    (in_pixel),
    .scanline_en (scanline_en),
    .out_de      (out_de),
    .out_hsync   (out_hsync),
    .out_pixel   (out_pixel)
  );

  linedbl_checker chk0 (
    .wrCLK       (wrCLK),
    .rdCLK       (rdCLK),
    .rst_n       (rst_n),
    .in_de       (in_de),
    .in_pixel    (in_pixel),
    .scanline_en (scanline_en),
    .out_de      (out_de),
    .out_hsync   (out_hsync),
    .out_pixel   (out_pixel),
    .err_cnt     (err_cnt),
    .chk_cnt     (chk_cnt),
    .lines_done  (lines_done),
    .hsync_cnt   (hsync_cnt),
    .de_cnt      (de_cnt)
  );

  //////////////////////////////////////////////////////////////
  // Stimulus and waits

  // len random pixels then blank wrCLK cycles, zero len gives blank only
  task automatic send_line(input int len, input int blank);
    logic [31:0] rnd;
    for (int i = 0; i < len; i++) begin
      @(negedge wrCLK);
      rnd      = $random(seed);
      in_de    = 1'b1;
      in_pixel = rnd[23:0];
    end
    for (int i = 0; i < blank; i++) begin
      @(negedge wrCLK);
      in_de    = 1'b0;
      in_pixel = '0;
    end
  endtask

  // Until the checker has seen target lines played twice
  task automatic wait_lines(input int target, input int limit);
    int n;
    n = 0;
    while (lines_done < target && n < limit) begin
      @(negedge rdCLK);
      n++;
    end
    if (lines_done < target) begin
      $display("Timeout: only %0d of %0d lines were played back", lines_done, target);
      fail_cnt++;
      timed_out = 1'b1;
    end
  endtask

  // Playback of n lines, two sync pulses each
  task automatic check_playback(input int n);
    wait_lines(lines_base + n, n * 2000);
    if (hsync_cnt - hs_base != 2 * n) begin
      $display("Error: out_hsync pulse count expected %h got %h", 2 * n, hsync_cnt - hs_base);
      fail_cnt++;
    end
  endtask

  // Outputs idle for a number of rdCLK cycles
  task automatic check_quiet(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge rdCLK);
      if (out_de !== 1'b0) begin
        $display("Error: out_de expected 0 got %h", out_de);
        fail_cnt++;
      end
      if (out_hsync !== 1'b0) begin
        $display("Error: out_hsync expected 0 got %h", out_hsync);
        fail_cnt++;
      end
    end
  endtask

  task automatic start_test();
    err_base   = err_cnt + fail_cnt;
    lines_base = lines_done;
    hs_base    = hsync_cnt;
    de_base    = de_cnt;
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = err_cnt + fail_cnt - err_base;
    test_cnt++;
    if (errs == 0) begin
      $display("Test %0d %s: ok", test_cnt, name);
    end else begin
      $display("Test %0d %s: FAILED with %0d errors", test_cnt, name, errs);
    end
  endtask

  //////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    seed        = 32'h427c_39c7;
    rst_n       = 1'b0;
    in_de       = 1'b0;
    in_pixel    = '0;
    scanline_en = 1'b0;
    fail_cnt    = 0;
    test_cnt    = 0;
    timed_out   = 1'b0;
    repeat (3) @(posedge rdCLK);
    @(negedge rdCLK);
    rst_n = 1'b1;

    start_test();
    check_quiet(40);
    end_test("quiet after reset");

    start_test();
    send_line(64, 12);
    check_playback(1);
    end_test("64 pixels doubled");

    // Dimming of the repeat copy
    start_test();
    @(negedge rdCLK);
    scanline_en = 1'b1;
    send_line(64, 12);
    check_playback(1);
    @(negedge rdCLK);
    scanline_en = 1'b0;
    end_test("scanline dimming");

    // Banks alternate from line to line
    start_test();
    send_line(1, 12);
    send_line(37, 12);
    send_line(200, 12);
    check_playback(3);
    end_test("lines of 1, 37 and 200");

    start_test();
    send_line(300, 12);
    check_playback(1);
    end_test("300 pixels clipped");

    start_test();
    send_line(0, 200);
    check_quiet(20);
    if (lines_done != lines_base || hsync_cnt != hs_base || de_cnt != de_base) begin
      $display("A blank-only period produced output activity");
      fail_cnt++;
    end
    end_test("blank only");

    $display("Tests %0d, checks %0d, errors %0d, lines played %0d",
             test_cnt, chk_cnt, err_cnt + fail_cnt, lines_done);
    if (err_cnt + fail_cnt == 0 && !timed_out) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- verilog.f
video_pkg.sv
lbuf_pkg.sv
cap_if.sv
scan_if.sv
n64a_ram2port.sv
line_capture.sv
scan_timer.sv
line_output.sv
linedbl_top.sv
linedbl_checker.sv
tb_linedbl.sv
